/* hw/wb_settings.svh */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// result slots per micro-op, fixes the port structure
`define WB_SLOTS 4

// registers per architectural file and index width
`define WB_NREGS 8
`define WB_RIDX_W 3

`define WBAQ_DEPTH 4

// offset bits cleared in the even/odd fetch-line addresses
`define FIP_LINE_BITS 4

`endif

/* hw/x86wb_pkg.sv */
package x86wb_pkg;

    // operand size codes as carried by the micro-op
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2,
        SZ_QWORD = 2'd3
    } size_e;

    typedef logic [31:0] gpr_t;  // general register
    typedef logic [15:0] seg_t;  // segment selector

    // one result slot of a retiring micro-op
    typedef struct packed {
        logic [63:0] data;
        logic [31:0] dest;    // reg index in [2:0], full address for memory
        logic        is_reg;
        logic        is_seg;
        logic        is_mem;
        logic        wb;      // slot actually produces a result
    } slot_t;

    typedef struct packed {
        logic halt;
        logic far_xfer;  // CS:EIP loaded from slot 0
    } uop_ctl_t;

    // pending memory write
    typedef struct packed {
        logic [31:0] addr;
        logic [63:0] data;
        size_e       size;
    } wbaq_entry_t;

endpackage

/* hw/wb_if.sv */
`timescale 1ns/1ps
`include "wb_settings.svh"

// write bundle from the stage into one register file
interface rf_write_if;
    logic [`WB_SLOTS-1:0]                 ld;    // one per slot
    logic [`WB_SLOTS-1:0][`WB_RIDX_W-1:0] addr;
    logic [`WB_SLOTS-1:0][63:0]           data;
    logic [`WB_SLOTS-1:0][7:0]            be;    // byte lanes of data

    modport writer (
        output ld,
        output addr,
        output data,
        output be
    );

    modport regfile (
        input ld,
        input addr,
        input data,
        input be
    );
endinterface

// push side of the write-back address queue
interface mem_push_if;
    import x86wb_pkg::*;

    logic        push;   // taken only while full is low
    wbaq_entry_t entry;
    logic        full;

    modport producer (
        output push,
        output entry,
        input  full
    );

    modport queue (
        input  push,
        input  entry,
        output full
    );
endinterface

/* hw/wb_stage.sv */
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_stage (
    input  logic                valid_in,
    input  x86wb_pkg::slot_t    slot [`WB_SLOTS],
    input  x86wb_pkg::size_e    inpsize,
    input  logic [3:0]          memsize_ovr,
    input  x86wb_pkg::uop_ctl_t uop_ctl,
    input  logic [31:0]         eip_in,
    input  logic                br_taken_in,
    input  logic                br_correct_in,
    input  logic [31:0]         br_fip_in,
    input  logic [31:0]         br_fip_p1_in,
    input  logic                ie_in,
    input  logic                interrupt_in,
    input  logic [3:0]          ie_type_in,
    rf_write_if.writer          gpr_wr,
    rf_write_if.writer          seg_wr,
    mem_push_if.producer        mem,
    output logic                valid_out,
    output logic                stall,
    output logic                is_resteer,
    output logic                final_ie_val,
    output logic                halts,
    output logic [31:0]         newEIP,
    output logic [31:0]         newFIP_e,
    output logic [31:0]         newFIP_o,
    output logic [3:0]          final_ie_type
);
    import x86wb_pkg::*;

    localparam logic [31:0] LINE_MASK = ~((32'd1 << `FIP_LINE_BITS) - 32'd1);

    logic [`WB_SLOTS-1:0] mem_req;
    logic                 any_mem;
    size_e                memsize;
    logic [7:0]           reg_be;
    logic [31:0]          fip_line;
    logic [31:0]          fip_p1_line;

    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            mem_req[i] = valid_in && slot[i].is_mem && slot[i].wb;
        end
    end

    assign any_mem   = |mem_req;
    assign stall     = any_mem && mem.full;  // queue cannot take the write
    assign valid_out = valid_in && !stall;
    assign mem.push  = valid_out && any_mem;

    always_comb begin
        case (inpsize)
            SZ_BYTE:  reg_be = 8'h01;
            SZ_WORD:  reg_be = 8'h03;
            SZ_DWORD: reg_be = 8'h0f;
            default:  reg_be = 8'hff;
        endcase
    end

    // general register writes
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            gpr_wr.ld[i]   = valid_out && slot[i].is_reg && slot[i].wb;
            gpr_wr.addr[i] = slot[i].dest[`WB_RIDX_W-1:0];
            gpr_wr.data[i] = slot[i].data;
            gpr_wr.be[i]   = reg_be;
        end
    end

    // segment writes are always one selector wide
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            seg_wr.ld[i]   = valid_out && slot[i].is_seg && slot[i].wb;
            seg_wr.addr[i] = slot[i].dest[`WB_RIDX_W-1:0];
            seg_wr.data[i] = slot[i].data;
            seg_wr.be[i]   = 8'h03;
        end
        if (uop_ctl.far_xfer) begin
            seg_wr.data[0] = {48'd0, slot[0].data[47:32]};  // CS selector above the offset
        end
    end

    // override bits win, lowest first
    always_comb begin
        if (memsize_ovr[0]) begin
            memsize = SZ_BYTE;
        end else if (memsize_ovr[1]) begin
            memsize = SZ_WORD;
        end else if (memsize_ovr[2]) begin
            memsize = SZ_DWORD;
        end else if (memsize_ovr[3]) begin
            memsize = SZ_QWORD;
        end else if (uop_ctl.far_xfer) begin
            memsize = SZ_DWORD;
        end else begin
            memsize = inpsize;
        end
    end

    always_comb begin
        mem.entry.addr = slot[0].dest;
        mem.entry.data = slot[0].data;
        mem.entry.size = memsize;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (mem_req[i]) begin
                mem.entry.addr = slot[i].dest;
                mem.entry.data = slot[i].data;
            end
        end
    end

    // fetch lines, swapped when the target sits in an odd line
    assign fip_line    = br_fip_in & LINE_MASK;
    assign fip_p1_line = br_fip_p1_in & LINE_MASK;
    assign newFIP_e    = br_fip_in[`FIP_LINE_BITS] ? fip_p1_line : fip_line;
    assign newFIP_o    = br_fip_in[`FIP_LINE_BITS] ? fip_line : fip_p1_line;

    always_comb begin
        if (!br_taken_in) begin
            newEIP = eip_in;
        end else if (uop_ctl.far_xfer) begin
            newEIP = slot[0].data[31:0];  // far jump offset
        end else begin
            newEIP = br_fip_in;
        end
    end

    assign is_resteer    = valid_out && !br_correct_in;
    assign final_ie_val  = ie_in || interrupt_in;
    assign final_ie_type = {interrupt_in, ie_type_in[2:0]};
    assign halts         = uop_ctl.halt && valid_in;

    // the queue takes one write per micro-op
    always_comb begin
        a_one_mem_slot: assert final ($onehot0(mem_req))
            else $error("wb_stage: several slots request memory %b", mem_req);
    end

endmodule

/* hw/wb_regfile.sv */
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_regfile #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                  clk,
    input  logic                  rst_n,
    rf_write_if.regfile           wr,
    input  logic [`WB_RIDX_W-1:0] rd_addr,
    output entry_t                rd_data
);

    localparam int W      = $bits(entry_t);
    localparam int NBYTES = W / 8;  // upper write bytes fall away

    logic [W-1:0] regs [`WB_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `WB_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later slots are assigned last and so win on a collision
            for (int s = 0; s < `WB_SLOTS; s++) begin
                if (wr.ld[s]) begin
                    for (int b = 0; b < NBYTES; b++) begin
                        if (wr.be[s][b]) begin
                            regs[wr.addr[s]][b*8 +: 8] <= wr.data[s][b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    assign rd_data = entry_t'(regs[rd_addr]);  // asynchronous read

    // the stage must hand over a clean index with every enable
    for (genvar s = 0; s < `WB_SLOTS; s++) begin : g_addr_chk
        a_addr_known: assert property (
            @(posedge clk) disable iff (!rst_n)
            wr.ld[s] |-> !$isunknown(wr.addr[s])
        ) else $error("wb_regfile: slot %0d write with unknown address", s);
    end

endmodule

/* hw/wbaq.sv */
`timescale 1ns/1ps
`include "wb_settings.svh"

module wbaq #(
    parameter int DEPTH = `WBAQ_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_push_if.queue              in,
    input  logic                   pop,
    output x86wb_pkg::wbaq_entry_t head,
    output logic                   not_empty
);
    import x86wb_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    wbaq_entry_t   q [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in.full   = (count == CW'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = in.push && !in.full;
    assign do_pop    = pop && not_empty;
    assign head      = q[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            q[wr_ptr] <= in.entry;
        end
    end

    // the stage stalls rather than push into a full queue
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) in.push |-> !in.full
    ) else $error("wbaq: push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> not_empty
    ) else $error("wbaq: grant while empty");

endmodule

/* hw/x86_wb_top.sv */
`timescale 1ns/1ps
`include "wb_settings.svh"

module x86_wb_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    input  logic [`WB_SLOTS-1:0][63:0] slot_data,
    input  logic [`WB_SLOTS-1:0][31:0] slot_dest,
    input  logic [`WB_SLOTS-1:0]       slot_is_reg,
    input  logic [`WB_SLOTS-1:0]       slot_is_seg,
    input  logic [`WB_SLOTS-1:0]       slot_is_mem,
    input  logic [`WB_SLOTS-1:0]       slot_wb,
    input  logic [1:0]                 inpsize,
    input  logic [3:0]                 memsize_ovr,
    input  logic                       uop_halt,
    input  logic                       uop_far_xfer,
    input  logic [31:0]                eip_in,
    input  logic                       br_valid_in,
    input  logic                       br_taken_in,
    input  logic                       br_correct_in,
    input  logic [31:0]                br_fip_in,
    input  logic [31:0]                br_fip_p1_in,
    input  logic [5:0]                 bp_alias_in,
    input  logic [15:0]                cs_in,
    input  logic [17:0]                eflags_in,
    input  logic                       ie_in,
    input  logic [3:0]                 ie_type_in,
    input  logic                       interrupt_in,
    input  logic                       mem_grant,
    output logic                       mem_wr_valid,
    output logic [31:0]                mem_wr_addr,
    output logic [63:0]                mem_wr_data,
    output logic [1:0]                 mem_wr_size,
    input  logic [`WB_RIDX_W-1:0]      gpr_rd_addr,
    output logic [31:0]                gpr_rd_data,
    input  logic [`WB_RIDX_W-1:0]      seg_rd_addr,
    output logic [15:0]                seg_rd_data,
    output logic                       valid_out,
    output logic                       stall,
    output logic [31:0]                newEIP,
    output logic [31:0]                newFIP_e,
    output logic [31:0]                newFIP_o,
    output logic                       is_resteer,
    output logic                       br_valid,
    output logic                       br_taken,
    output logic                       br_correct,
    output logic [5:0]                 wb_bp_update_alias,
    output logic [15:0]                cs_out,
    output logic [17:0]                eflags_out,
    output logic                       final_ie_val,
    output logic [3:0]                 final_ie_type,
    output logic                       halts
);
    import x86wb_pkg::*;

    slot_t       slot [`WB_SLOTS];
    uop_ctl_t    uop_ctl;
    wbaq_entry_t head;

    rf_write_if gpr_wr ();
    rf_write_if seg_wr ();
    mem_push_if mem_push ();

    // regroup the flat slot fields
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            slot[i].data   = slot_data[i];
            slot[i].dest   = slot_dest[i];
            slot[i].is_reg = slot_is_reg[i];
            slot[i].is_seg = slot_is_seg[i];
            slot[i].is_mem = slot_is_mem[i];
            slot[i].wb     = slot_wb[i];
        end
    end

    assign uop_ctl.halt     = uop_halt;
    assign uop_ctl.far_xfer = uop_far_xfer;

    wb_stage u_stage (
        .valid_in      (valid_in),
        .slot          (slot),
        .inpsize       (size_e'(inpsize)),
        .memsize_ovr   (memsize_ovr),
        .uop_ctl       (uop_ctl),
        .eip_in        (eip_in),
        .br_taken_in   (br_taken_in),
        .br_correct_in (br_correct_in),
        .br_fip_in     (br_fip_in),
        .br_fip_p1_in  (br_fip_p1_in),
        .ie_in         (ie_in),
        .interrupt_in  (interrupt_in),
        .ie_type_in    (ie_type_in),
        .gpr_wr        (gpr_wr),
        .seg_wr        (seg_wr),
        .mem           (mem_push),
        .valid_out     (valid_out),
        .stall         (stall),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .halts         (halts),
        .newEIP        (newEIP),
        .newFIP_e      (newFIP_e),
        .newFIP_o      (newFIP_o),
        .final_ie_type (final_ie_type)
    );

    wb_regfile #(.entry_t(gpr_t)) u_gpr (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (gpr_wr),
        .rd_addr (gpr_rd_addr),
        .rd_data (gpr_rd_data)
    );

    wb_regfile #(.entry_t(seg_t)) u_seg (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (seg_wr),
        .rd_addr (seg_rd_addr),
        .rd_data (seg_rd_data)
    );

    wbaq #(.DEPTH(`WBAQ_DEPTH)) u_wbaq (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (mem_push),
        .pop       (mem_grant),
        .head      (head),
        .not_empty (mem_wr_valid)
    );

    assign mem_wr_addr = head.addr;
    assign mem_wr_data = head.data;
    assign mem_wr_size = head.size;

    // status passed straight on
    assign br_valid           = br_valid_in;
    assign br_taken           = br_taken_in;
    assign br_correct         = br_correct_in;
    assign wb_bp_update_alias = bp_alias_in;
    assign cs_out             = cs_in;
    assign eflags_out         = eflags_in;

endmodule

/* verification/wb_tb.sv */
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_tb;

    localparam int MAX_CYCLES = 2000;  // generous bound over all five tests

    // one retiring micro-op as seen on the top-level ports
    typedef struct packed {
        logic                       valid;
        logic [`WB_SLOTS-1:0][63:0] data;
        logic [`WB_SLOTS-1:0][31:0] dest;
        logic [`WB_SLOTS-1:0]       is_reg;
        logic [`WB_SLOTS-1:0]       is_seg;
        logic [`WB_SLOTS-1:0]       is_mem;
        logic [`WB_SLOTS-1:0]       wb;
        logic [1:0]                 inpsize;
        logic [3:0]                 ovr;
        logic                       halt;
        logic                       far;
        logic [31:0]                eip;
        logic                       br_valid;
        logic                       br_taken;
        logic                       br_correct;
        logic [31:0]                br_fip;
        logic [31:0]                br_fip_p1;
        logic [5:0]                 bp_alias;
        logic [15:0]                cs;
        logic [17:0]                eflags;
        logic                       ie;
        logic [3:0]                 ie_type;
        logic                       intr;
    } stim_t;

    logic        clk;
    logic        rst_n;
    stim_t       stim;  // built by the tests
    stim_t       drv;   // what the DUT sees
    logic        mem_grant;
    logic [2:0]  gpr_rd_addr;
    logic [2:0]  seg_rd_addr;
    logic        mem_wr_valid;
    logic [31:0] mem_wr_addr;
    logic [63:0] mem_wr_data;
    logic [1:0]  mem_wr_size;
    logic [31:0] gpr_rd_data;
    logic [15:0] seg_rd_data;
    logic        valid_out;
    logic        stall;
    logic [31:0] newEIP;
    logic [31:0] newFIP_e;
    logic [31:0] newFIP_o;
    logic        is_resteer;
    logic        br_valid;
    logic        br_taken;
    logic        br_correct;
    logic [5:0]  wb_bp_update_alias;
    logic [15:0] cs_out;
    logic [17:0] eflags_out;
    logic        final_ie_val;
    logic [3:0]  final_ie_type;
    logic        halts;

    logic [31:0] gpr_sh [`WB_NREGS];  // shadow register files
    logic [15:0] seg_sh [`WB_NREGS];
    logic [97:0] exp_mem [$];         // {addr, data, size} in push order
    string       cur_test;
    int          errs_at_start;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;

    x86_wb_top DUT (
        .clk(clk), .rst_n(rst_n), .valid_in(drv.valid),
        .slot_data(drv.data), .slot_dest(drv.dest), .slot_is_reg(drv.is_reg),
        .slot_is_seg(drv.is_seg), .slot_is_mem(drv.is_mem), .slot_wb(drv.wb),
        .inpsize(drv.inpsize), .memsize_ovr(drv.ovr), .uop_halt(drv.halt),
        .uop_far_xfer(drv.far), .eip_in(drv.eip), .br_valid_in(drv.br_valid),
        .br_taken_in(drv.br_taken), .br_correct_in(drv.br_correct),
        .br_fip_in(drv.br_fip), .br_fip_p1_in(drv.br_fip_p1), .bp_alias_in(drv.bp_alias),
        .cs_in(drv.cs), .eflags_in(drv.eflags), .ie_in(drv.ie), .ie_type_in(drv.ie_type),
        .interrupt_in(drv.intr), .mem_grant(mem_grant), .mem_wr_valid(mem_wr_valid),
        .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data), .mem_wr_size(mem_wr_size),
        .gpr_rd_addr(gpr_rd_addr), .gpr_rd_data(gpr_rd_data),
        .seg_rd_addr(seg_rd_addr), .seg_rd_data(seg_rd_data),
        .valid_out(valid_out), .stall(stall), .newEIP(newEIP), .newFIP_e(newFIP_e),
        .newFIP_o(newFIP_o), .is_resteer(is_resteer), .br_valid(br_valid),
        .br_taken(br_taken), .br_correct(br_correct), .wb_bp_update_alias(wb_bp_update_alias),
        .cs_out(cs_out), .eflags_out(eflags_out), .final_ie_val(final_ie_val),
        .final_ie_type(final_ie_type), .halts(halts)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic void clear_stim();
        stim            = '0;
        stim.valid      = 1'b1;
        stim.inpsize    = 2'd2;
        stim.br_correct = 1'b1;
    endfunction

    function automatic void put_slot(input int s, input logic is_reg, input logic is_seg,
                                     input logic is_mem, input logic [31:0] dest,
                                     input logic [63:0] data);
        stim.is_reg[s] = is_reg;
        stim.is_seg[s] = is_seg;
        stim.is_mem[s] = is_mem;
        stim.wb[s]     = 1'b1;
        stim.dest[s]   = dest;
        stim.data[s]   = data;
    endfunction

    // first override bit wins, then far transfers are dword
    function automatic logic [1:0] exp_memsize();
        if (stim.ovr[0]) return 2'd0;
        if (stim.ovr[1]) return 2'd1;
        if (stim.ovr[2]) return 2'd2;
        if (stim.ovr[3]) return 2'd3;
        if (stim.far) return 2'd2;
        return stim.inpsize;
    endfunction

    // reference model for an accepted micro-op with slots in ascending order
    function automatic void commit_model();
        int          nb;
        logic [2:0]  r;
        nb = 1 << stim.inpsize;
        for (int s = 0; s < `WB_SLOTS; s++) begin
            r = stim.dest[s][2:0];
            if (stim.wb[s] && stim.is_reg[s]) begin
                for (int b = 0; b < 4 && b < nb; b++) begin
                    gpr_sh[r][b*8 +: 8] = stim.data[s][b*8 +: 8];
                end
            end
            if (stim.wb[s] && stim.is_seg[s]) begin
                seg_sh[r] = (stim.far && s == 0) ? stim.data[s][47:32] : stim.data[s][15:0];
            end
            if (stim.wb[s] && stim.is_mem[s]) begin
                exp_mem.push_back({stim.dest[s], stim.data[s], exp_memsize()});
            end
        end
    endfunction

    task automatic send_uop();
        logic        any_mem;
        logic        exp_stall;
        logic        exp_vo;
        logic [31:0] line_a;
        logic [31:0] line_b;
        logic [31:0] exp_eip;
        any_mem = 1'b0;
        for (int s = 0; s < `WB_SLOTS; s++) begin
            any_mem = any_mem | (stim.wb[s] & stim.is_mem[s]);
        end
        exp_stall = stim.valid && any_mem && (exp_mem.size() == `WBAQ_DEPTH);
        exp_vo    = stim.valid && !exp_stall;
        line_a    = stim.br_fip & 32'hffff_fff0;
        line_b    = stim.br_fip_p1 & 32'hffff_fff0;
        if (!stim.br_taken) begin
            exp_eip = stim.eip;
        end else begin
            exp_eip = stim.far ? stim.data[0][31:0] : stim.br_fip;
        end
        @(posedge clk);
        drv <= stim;
        @(negedge clk);  // combinational outputs settled
        check("stall", exp_stall, stall);
        check("valid_out", exp_vo, valid_out);
        check("newEIP", exp_eip, newEIP);
        check("newFIP_e", stim.br_fip[4] ? line_b : line_a, newFIP_e);
        check("newFIP_o", stim.br_fip[4] ? line_a : line_b, newFIP_o);
        check("is_resteer", exp_vo && !stim.br_correct, is_resteer);
        check("final_ie_val", stim.ie | stim.intr, final_ie_val);
        check("final_ie_type", {stim.intr, stim.ie_type[2:0]}, final_ie_type);
        check("halts", stim.halt & stim.valid, halts);
        check("br_valid", stim.br_valid, br_valid);
        check("br_taken", stim.br_taken, br_taken);
        check("br_correct", stim.br_correct, br_correct);
        check("alias", stim.bp_alias, wb_bp_update_alias);
        check("cs_out", stim.cs, cs_out);
        check("eflags_out", stim.eflags, eflags_out);
        if (exp_vo) begin
            commit_model();
        end
        @(posedge clk);  // write edge
        drv.valid <= 1'b0;
    endtask

    task automatic check_regs();
        for (int r = 0; r < `WB_NREGS; r++) begin
            @(posedge clk);
            gpr_rd_addr <= 3'(r);
            seg_rd_addr <= 3'(r);
            @(negedge clk);
            check($sformatf("gpr[%0d]", r), gpr_sh[r], gpr_rd_data);
            check($sformatf("seg[%0d]", r), seg_sh[r], seg_rd_data);
        end
    endtask

    task automatic drain_one();
        logic [97:0] e;
        e = exp_mem.pop_front();
        @(negedge clk);
        check("mem_wr_valid", 1'b1, mem_wr_valid);
        check("mem_wr_addr", e[97:66], mem_wr_addr);
        check("mem_wr_data", e[65:2], mem_wr_data);
        check("mem_wr_size", e[1:0], mem_wr_size);
        @(posedge clk);
        mem_grant <= 1'b1;
        @(posedge clk);  // head pops here
        mem_grant <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (n_errors == errs_at_start) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: FAILED with %0d errors", cur_test, n_errors - errs_at_start);
        end
    endtask

    task automatic gpr_sizes();
        begin_test("gpr_sizes");
        @(negedge clk);
        check("mem_wr_valid", 1'b0, mem_wr_valid);
        check_regs();  // all zero out of reset
        clear_stim();
        put_slot(0, 1, 0, 0, 32'd1, rand64());
        put_slot(1, 1, 0, 0, 32'd2, rand64());
        put_slot(3, 1, 0, 0, 32'd7, rand64());
        send_uop();
        clear_stim();
        stim.inpsize = 2'd0;
        put_slot(0, 1, 0, 0, 32'd1, rand64());
        put_slot(2, 1, 0, 0, 32'd1, rand64());  // collides with slot 0
        put_slot(1, 1, 0, 0, 32'd2, rand64());
        send_uop();
        clear_stim();
        stim.inpsize = 2'd1;
        put_slot(0, 1, 0, 0, 32'd5, rand64());
        put_slot(1, 1, 0, 0, 32'd2, rand64());
        put_slot(3, 1, 0, 0, 32'd2, rand64());
        stim.is_reg[2] = 1'b1;  // flagged but no result
        stim.is_seg[2] = 1'b1;
        stim.is_mem[2] = 1'b1;
        stim.data[2]   = rand64();
        stim.dest[2]   = 32'd7;
        send_uop();
        clear_stim();
        stim.inpsize = 2'd3;
        put_slot(2, 1, 0, 0, 32'd5, rand64());
        send_uop();
        check_regs();
        check("mem_wr_valid", 1'b0, mem_wr_valid);  // no memory write yet
        end_test();
    endtask

    task automatic seg_far();
        begin_test("seg_far");
        clear_stim();
        put_slot(1, 0, 1, 0, 32'd3, rand64());
        put_slot(2, 0, 1, 0, 32'd5, rand64());
        put_slot(3, 1, 1, 0, 32'd4, rand64());  // both files from one slot
        send_uop();
        clear_stim();
        stim.far      = 1'b1;
        stim.br_taken = 1'b1;
        stim.br_fip   = $urandom;
        put_slot(0, 0, 1, 0, 32'd1, rand64());  // selector from data[47:32]
        put_slot(2, 0, 1, 0, 32'd6, rand64());
        send_uop();
        check_regs();
        end_test();
    endtask

    task automatic wbaq_order_stall();
        logic [3:0] ovr [5] = '{4'b0000, 4'b0110, 4'b1000, 4'b0000, 4'b0101};
        logic [1:0] isz [5] = '{2'd1, 2'd0, 2'd0, 2'd0, 2'd2};
        begin_test("wbaq_order_stall");
        for (int i = 0; i < 5; i++) begin
            clear_stim();
            stim.ovr     = ovr[i];
            stim.inpsize = isz[i];
            stim.far     = (i == 3);  // dword without override
            put_slot(i % 4, 0, 0, 1, $urandom, rand64());
            if (i == 4) begin
                put_slot(1, 1, 0, 0, 32'd6, rand64());
            end
            send_uop();
        end
        check_regs();  // stalled op left gpr[6] alone
        drain_one();
        send_uop();    // upstream replays the stalled op
        for (int i = 0; i < `WBAQ_DEPTH; i++) begin
            drain_one();
        end
        @(negedge clk);
        check("mem_wr_valid", 1'b0, mem_wr_valid);
        check_regs();
        end_test();
    endtask

    task automatic branch_resteer();
        begin_test("branch_resteer");
        for (int i = 0; i < 10; i++) begin
            clear_stim();
            stim.eip        = $urandom;
            stim.br_fip     = $urandom;
            stim.br_fip_p1  = stim.br_fip + 32'd16;
            stim.br_taken   = 1'($urandom);
            stim.br_correct = 1'($urandom);
            stim.far        = (i == 9);
            stim.data[0]    = rand64();
            send_uop();
        end
        end_test();
    endtask

    task automatic exceptions_halt();
        begin_test("exceptions_halt");
        for (int i = 0; i < 10; i++) begin
            clear_stim();
            stim.valid      = 1'($urandom);
            stim.ie         = 1'($urandom);
            stim.intr       = 1'($urandom);
            stim.ie_type    = 4'($urandom);
            stim.halt       = 1'($urandom);
            stim.cs         = 16'($urandom);
            stim.eflags     = 18'($urandom);
            stim.bp_alias   = 6'($urandom);
            stim.br_valid   = 1'($urandom);
            stim.br_correct = 1'($urandom);  // resteer only with a valid op
            send_uop();
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h9cffe1e8));
        for (int r = 0; r < `WB_NREGS; r++) begin
            gpr_sh[r] = '0;
            seg_sh[r] = '0;
        end
        clear_stim();
        stim.valid = 1'b0;
        drv         <= stim;
        rst_n       <= 1'b0;
        mem_grant   <= 1'b0;
        gpr_rd_addr <= '0;
        seg_rd_addr <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        gpr_sizes();
        seg_far();
        wbaq_order_stall();
        branch_resteer();
        exceptions_halt();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* x86_writeback.f */
+incdir+hw
hw/x86wb_pkg.sv
hw/wb_if.sv
hw/wb_stage.sv
hw/wb_regfile.sv
hw/wbaq.sv
hw/x86_wb_top.sv
verification/wb_tb.sv

/* Bender.yml */
package:
  name: x86_writeback

export_include_dirs:
  - hw

sources:
  - files:
      - hw/x86wb_pkg.sv
      - hw/wb_if.sv
      - hw/wb_stage.sv
      - hw/wb_regfile.sv
      - hw/wbaq.sv
      - hw/x86_wb_top.sv
  - target: test
    files:
      - verification/wb_tb.sv
